// File: source/kyber_sched_pkg.sv
package kyber_sched_pkg;

    // Scheme selected at start (2'd3 is not a valid mode)
    typedef enum logic [1:0] {
        MODE_KEYGEN = 2'd0,
        MODE_ENC    = 2'd1,
        MODE_DEC    = 2'd2
    } scheme_mode_t;

    // Operations understood by the NTT/arithmetic core
    typedef enum logic [2:0] {
        OP_NTT  = 3'd0, // Forward NTT
        OP_INTT = 3'd1, // Inverse NTT
        OP_MUL  = 3'd2, // Pointwise multiply
        OP_ADD  = 3'd3,
        OP_SUB  = 3'd4
    } ntt_op_t;

    // One of eight polynomial banks
    typedef logic [2:0] bank_t;

    // Words per polynomial bank in the core RAM
    localparam int BANK_WORDS = 32;

    // RAM start offset
    localparam int OFFSET_W = 8;

    typedef logic [OFFSET_W-1:0] offset_t;

    // Command list lengths per mode
    localparam int KEYGEN_LEN = 12;
    localparam int ENC_LEN    = 18;
    localparam int DEC_LEN    = 7;

    // Table index and completion count
    localparam int SEQ_IDX_W = 5;

endpackage

// File: source/cmd_sequencer.sv
`timescale 1ns/10ps

module cmd_sequencer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  kyber_sched_pkg::scheme_mode_t mode,
    input  logic                          full,
    input  logic                          op_done,
    output logic                          push,
    output kyber_sched_pkg::ntt_op_t      cmd_op,
    output kyber_sched_pkg::bank_t        cmd_bank_a,
    output kyber_sched_pkg::bank_t        cmd_bank_b,
    output kyber_sched_pkg::bank_t        cmd_bank_w,
    output logic                          finish
);
    import kyber_sched_pkg::*;

    scheme_mode_t         mode_q;
    logic [SEQ_IDX_W-1:0] idx;      // Next command to push
    logic [SEQ_IDX_W-1:0] done_cnt; // Commands acknowledged by the core
    logic [SEQ_IDX_W-1:0] len;
    logic [11:0]          entry;    // {op, bank a, bank b, bank w}
    logic                 start_ok;

    assign start_ok = start && finish && (mode inside {MODE_KEYGEN, MODE_ENC, MODE_DEC});

    always_comb begin
        case (mode_q)
            MODE_KEYGEN: len = SEQ_IDX_W'(KEYGEN_LEN);
            MODE_ENC:    len = SEQ_IDX_W'(ENC_LEN);
            MODE_DEC:    len = SEQ_IDX_W'(DEC_LEN);
            default:     len = '0;
        endcase
    end

    assign push = !finish && (idx < len) && !full;

    // Command tables per mode with one bank in all fields for NTT/INTT
    always_comb begin
        entry = {OP_NTT, 9'd0};
        case (mode_q)
            MODE_KEYGEN: begin
                case (idx)
                    5'd0:  entry = {OP_NTT, 3'd4, 3'd4, 3'd4};
                    5'd1:  entry = {OP_NTT, 3'd5, 3'd5, 3'd5};
                    5'd2:  entry = {OP_MUL, 3'd0, 3'd4, 3'd0};
                    5'd3:  entry = {OP_MUL, 3'd1, 3'd5, 3'd1};
                    5'd4:  entry = {OP_NTT, 3'd6, 3'd6, 3'd6};
                    5'd5:  entry = {OP_ADD, 3'd0, 3'd1, 3'd0};
                    5'd6:  entry = {OP_ADD, 3'd0, 3'd6, 3'd6};
                    5'd7:  entry = {OP_MUL, 3'd2, 3'd4, 3'd2};
                    5'd8:  entry = {OP_MUL, 3'd3, 3'd5, 3'd3};
                    5'd9:  entry = {OP_NTT, 3'd7, 3'd7, 3'd7};
                    5'd10: entry = {OP_ADD, 3'd2, 3'd3, 3'd2};
                    5'd11: entry = {OP_ADD, 3'd2, 3'd7, 3'd7};
                    default: entry = {OP_NTT, 9'd0};
                endcase
            end
            MODE_ENC: begin
                case (idx)
                    5'd0:  entry = {OP_NTT, 3'd4, 3'd4, 3'd4};
                    5'd1:  entry = {OP_NTT, 3'd5, 3'd5, 3'd5};
                    5'd2:  entry = {OP_MUL, 3'd0, 3'd4, 3'd0};
                    5'd3:  entry = {OP_MUL, 3'd2, 3'd5, 3'd2};
                    5'd4:  entry = {OP_ADD, 3'd0, 3'd2, 3'd0};
                    5'd5:  entry = {OP_INTT, 3'd0, 3'd0, 3'd0};
                    5'd6:  entry = {OP_ADD, 3'd0, 3'd6, 3'd6};
                    5'd7:  entry = {OP_MUL, 3'd1, 3'd4, 3'd1};
                    5'd8:  entry = {OP_MUL, 3'd3, 3'd5, 3'd3};
                    5'd9:  entry = {OP_ADD, 3'd1, 3'd3, 3'd3};
                    5'd10: entry = {OP_INTT, 3'd3, 3'd3, 3'd3};
                    5'd11: entry = {OP_ADD, 3'd3, 3'd7, 3'd7};
                    5'd12: entry = {OP_MUL, 3'd0, 3'd4, 3'd0};
                    5'd13: entry = {OP_MUL, 3'd1, 3'd5, 3'd1};
                    5'd14: entry = {OP_ADD, 3'd0, 3'd1, 3'd0};
                    5'd15: entry = {OP_INTT, 3'd0, 3'd0, 3'd0};
                    5'd16: entry = {OP_ADD, 3'd0, 3'd2, 3'd0};
                    5'd17: entry = {OP_ADD, 3'd0, 3'd3, 3'd0};
                    default: entry = {OP_NTT, 9'd0};
                endcase
            end
            MODE_DEC: begin
                case (idx)
                    5'd0: entry = {OP_NTT, 3'd0, 3'd0, 3'd0};
                    5'd1: entry = {OP_NTT, 3'd1, 3'd1, 3'd1};
                    5'd2: entry = {OP_MUL, 3'd0, 3'd3, 3'd0};
                    5'd3: entry = {OP_MUL, 3'd1, 3'd4, 3'd1};
                    5'd4: entry = {OP_ADD, 3'd0, 3'd1, 3'd0};
                    5'd5: entry = {OP_INTT, 3'd0, 3'd0, 3'd0};
                    5'd6: entry = {OP_SUB, 3'd2, 3'd0, 3'd0}; // v minus s*u
                    default: entry = {OP_NTT, 9'd0};
                endcase
            end
            default: entry = {OP_NTT, 9'd0};
        endcase
    end

    assign cmd_op     = ntt_op_t'(entry[11:9]);
    assign cmd_bank_a = entry[8:6];
    assign cmd_bank_b = entry[5:3];
    assign cmd_bank_w = entry[2:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            finish   <= 1'b1;
            mode_q   <= MODE_KEYGEN;
            idx      <= '0;
            done_cnt <= '0;
        end else if (start_ok) begin
            finish   <= 1'b0;
            mode_q   <= mode;
            idx      <= '0;
            done_cnt <= '0;
        end else if (!finish) begin
            if (push) begin
                idx <= idx + 1'b1;
            end
            if (op_done) begin
                done_cnt <= done_cnt + 1'b1;
                if (done_cnt == len - 1'b1) begin
                    finish <= 1'b1; // Last command acknowledged
                end
            end
        end
    end

endmodule

// File: source/cmd_fifo.sv
`timescale 1ns/10ps

module cmd_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  logic                     pop,
    input  kyber_sched_pkg::ntt_op_t in_op,
    input  kyber_sched_pkg::bank_t   in_bank_a,
    input  kyber_sched_pkg::bank_t   in_bank_b,
    input  kyber_sched_pkg::bank_t   in_bank_w,
    output kyber_sched_pkg::ntt_op_t out_op,
    output kyber_sched_pkg::bank_t   out_bank_a,
    output kyber_sched_pkg::bank_t   out_bank_b,
    output kyber_sched_pkg::bank_t   out_bank_w,
    output logic                     full,
    output logic                     empty
);
    import kyber_sched_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ntt_op_t          op_mem     [DEPTH];
    bank_t            bank_a_mem [DEPTH];
    bank_t            bank_b_mem [DEPTH];
    bank_t            bank_w_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    // Head entry is visible before pop
    assign out_op     = op_mem[rd_ptr];
    assign out_bank_a = bank_a_mem[rd_ptr];
    assign out_bank_b = bank_b_mem[rd_ptr];
    assign out_bank_w = bank_w_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            op_mem[wr_ptr]     <= in_op;
            bank_a_mem[wr_ptr] <= in_bank_a;
            bank_b_mem[wr_ptr] <= in_bank_b;
            bank_w_mem[wr_ptr] <= in_bank_w;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: source/ntt_issue.sv
`timescale 1ns/10ps

module ntt_issue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     empty,
    input  kyber_sched_pkg::ntt_op_t cmd_op,
    input  kyber_sched_pkg::bank_t   cmd_bank_a,
    input  kyber_sched_pkg::bank_t   cmd_bank_b,
    input  kyber_sched_pkg::bank_t   cmd_bank_w,
    input  logic                     wb_ack,
    output logic                     pop,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output kyber_sched_pkg::ntt_op_t ntt_op,
    output kyber_sched_pkg::offset_t ntt_offset_a,
    output kyber_sched_pkg::offset_t ntt_offset_b,
    output kyber_sched_pkg::offset_t ntt_offset_w,
    output logic                     op_done
);
    import kyber_sched_pkg::*;

    typedef enum logic {
        IDLE,
        BUS
    } issue_state_t;

    issue_state_t state;

    assign pop     = (state == IDLE) && !empty;
    assign wb_cyc  = (state == BUS);
    assign wb_stb  = (state == BUS);
    assign wb_we   = wb_cyc; // Every transfer is a write
    assign op_done = (state == BUS) && wb_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) begin
                        state <= BUS;
                    end
                end
                BUS: begin
                    if (wb_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Command held on the bus until ack
    always_ff @(posedge clk) begin
        if (pop) begin
            ntt_op       <= cmd_op;
            ntt_offset_a <= offset_t'(cmd_bank_a * BANK_WORDS);
            ntt_offset_b <= offset_t'(cmd_bank_b * BANK_WORDS);
            ntt_offset_w <= offset_t'(cmd_bank_w * BANK_WORDS);
        end
    end

endmodule

// File: source/kyber_sched_top.sv
`timescale 1ns/10ps

module kyber_sched_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  kyber_sched_pkg::scheme_mode_t mode,
    output logic                          finish,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic                          wb_we,
    output kyber_sched_pkg::ntt_op_t      ntt_op,
    output kyber_sched_pkg::offset_t      ntt_offset_a,
    output kyber_sched_pkg::offset_t      ntt_offset_b,
    output kyber_sched_pkg::offset_t      ntt_offset_w,
    input  logic                          wb_ack
);
    import kyber_sched_pkg::*;

    logic    push;
    logic    pop;
    logic    full;
    logic    empty;
    logic    op_done;
    ntt_op_t cmd_op;
    bank_t   cmd_bank_a;
    bank_t   cmd_bank_b;
    bank_t   cmd_bank_w;
    ntt_op_t fifo_op;
    bank_t   fifo_bank_a;
    bank_t   fifo_bank_b;
    bank_t   fifo_bank_w;

    cmd_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .mode       (mode),
        .full       (full),
        .op_done    (op_done),
        .push       (push),
        .cmd_op     (cmd_op),
        .cmd_bank_a (cmd_bank_a),
        .cmd_bank_b (cmd_bank_b),
        .cmd_bank_w (cmd_bank_w),
        .finish     (finish)
    );

    cmd_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .pop        (pop),
        .in_op      (cmd_op),
        .in_bank_a  (cmd_bank_a),
        .in_bank_b  (cmd_bank_b),
        .in_bank_w  (cmd_bank_w),
        .out_op     (fifo_op),
        .out_bank_a (fifo_bank_a),
        .out_bank_b (fifo_bank_b),
        .out_bank_w (fifo_bank_w),
        .full       (full),
        .empty      (empty)
    );

    ntt_issue u_issue (
        .clk          (clk),
        .rst          (rst),
        .empty        (empty),
        .cmd_op       (fifo_op),
        .cmd_bank_a   (fifo_bank_a),
        .cmd_bank_b   (fifo_bank_b),
        .cmd_bank_w   (fifo_bank_w),
        .wb_ack       (wb_ack),
        .pop          (pop),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .ntt_op       (ntt_op),
        .ntt_offset_a (ntt_offset_a),
        .ntt_offset_b (ntt_offset_b),
        .ntt_offset_w (ntt_offset_w),
        .op_done      (op_done)
    );

endmodule

// File: verification/kyber_sched_assertions.sv
`timescale 1ns/10ps

module kyber_sched_assertions (
    input logic                     clk,
    input logic                     rst,
    input logic                     wb_cyc,
    input logic                     wb_stb,
    input logic                     wb_ack,
    input logic                     finish,
    input kyber_sched_pkg::ntt_op_t ntt_op,
    input kyber_sched_pkg::offset_t ntt_offset_a,
    input kyber_sched_pkg::offset_t ntt_offset_b,
    input kyber_sched_pkg::offset_t ntt_offset_w
);
    int fail_cnt = 0; // Read by the testbench at the end

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high without wb_cyc");
            fail_cnt++;
        end

    // Command held until the core acknowledges
    cmd_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(ntt_op) && $stable(ntt_offset_a)
                                 && $stable(ntt_offset_b) && $stable(ntt_offset_w)))
        else begin
            $error("Command fields changed before wb_ack");
            fail_cnt++;
        end

    no_finish_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_cyc |-> !finish)
        else begin
            $error("finish high during a bus cycle");
            fail_cnt++;
        end

endmodule

// File: verification/kyber_sched_tb.sv
`timescale 1ns/10ps

module kyber_sched_tb;
    import kyber_sched_pkg::*;

    logic         clk = 1'b0;
    logic         rst;
    logic         start;
    scheme_mode_t mode;
    logic         wb_ack;
    logic         finish;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    ntt_op_t      ntt_op;
    offset_t      ntt_offset_a;
    offset_t      ntt_offset_b;
    offset_t      ntt_offset_w;
    logic [31:0]  lfsr;

    // Hex nibbles are op, bank a, bank b, bank w
    localparam logic [15:0] KEYGEN_TAB [12] = '{
        16'h0444, 16'h0555, 16'h2040, 16'h2151, 16'h0666, 16'h3010,
        16'h3066, 16'h2242, 16'h2353, 16'h0777, 16'h3232, 16'h3277};
    localparam logic [15:0] ENC_TAB [18] = '{
        16'h0444, 16'h0555, 16'h2040, 16'h2252, 16'h3020, 16'h1000,
        16'h3066, 16'h2141, 16'h2353, 16'h3133, 16'h1333, 16'h3377,
        16'h2040, 16'h2151, 16'h3010, 16'h1000, 16'h3020, 16'h3030};
    localparam logic [15:0] DEC_TAB [7] = '{
        16'h0000, 16'h0111, 16'h2030, 16'h2141, 16'h3010, 16'h1000, 16'h4200};

    kyber_sched_top #(.FIFO_DEPTH(4)) DUT (.*);

    bind kyber_sched_top kyber_sched_assertions u_assert (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_ack       (wb_ack),
        .finish       (finish),
        .ntt_op       (ntt_op),
        .ntt_offset_a (ntt_offset_a),
        .ntt_offset_b (ntt_offset_b),
        .ntt_offset_w (ntt_offset_w)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [15:0] sched_entry(input scheme_mode_t m, input int i);
        case (m)
            MODE_KEYGEN: return KEYGEN_TAB[i];
            MODE_ENC:    return ENC_TAB[i];
            default:     return DEC_TAB[i];
        endcase
    endfunction

    function automatic int sched_len(input scheme_mode_t m);
        case (m)
            MODE_KEYGEN: return KEYGEN_LEN;
            MODE_ENC:    return ENC_LEN;
            default:     return DEC_LEN;
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            report_failure($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    always @(negedge clk) begin
        assert (DUT.u_assert.fail_cnt == 0) else begin
            report_failure("A bus protocol assertion in the bound checker failed");
        end
    end

    // Quiet bus and finish high for n cycles
    task automatic expect_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            check_hex("finish", 32'(finish), 32'h1);
            check_hex("wb_cyc", 32'(wb_cyc), 32'h0);
        end
    endtask

    task automatic try_invalid_start();
        @(posedge clk);
        start <= 1'b1;
        mode  <= scheme_mode_t'(2'd3);
        @(posedge clk);
        start <= 1'b0;
        expect_idle(8);
    endtask

    task automatic run_mode(input scheme_mode_t m);
        int          n;
        int          wait_cnt;
        logic [15:0] e;
        logic [31:0] delay;
        logic [31:0] stray;
        logic [31:0] rmode;
        n = sched_len(m);
        @(posedge clk);
        start <= 1'b1;
        mode  <= m;
        @(posedge clk);
        start <= 1'b0;
        for (int i = 0; i < n; i++) begin
            e = sched_entry(m, i);
            wait_cnt = 0;
            do begin
                @(negedge clk);
                check_hex("finish", 32'(finish), 32'h0);
                wait_cnt++;
                assert (wait_cnt < 50) else begin
                    report_failure($sformatf("Timeout: command %0d never reached the bus", i));
                end
            end while (!wb_stb);
            check_hex("wb_cyc", 32'(wb_cyc), 32'h1);
            check_hex("wb_we", 32'(wb_we), 32'h1);
            check_hex("ntt_op", 32'(ntt_op), 32'(e[14:12]));
            check_hex("ntt_offset_a", 32'(ntt_offset_a), 32'(e[10:8]) * BANK_WORDS);
            check_hex("ntt_offset_b", 32'(ntt_offset_b), 32'(e[6:4]) * BANK_WORDS);
            check_hex("ntt_offset_w", 32'(ntt_offset_w), 32'(e[2:0]) * BANK_WORDS);
            take_bits(3, delay); // Core latency with stray starts in between
            for (int d = 0; d < int'(delay); d++) begin
                @(posedge clk);
                take_bits(3, stray);
                take_bits(2, rmode);
                start <= (stray == 32'd7);
                mode  <= scheme_mode_t'(rmode[1:0]);
            end
            @(posedge clk);
            start  <= 1'b0;
            wb_ack <= 1'b1;
            @(posedge clk);
            wb_ack <= 1'b0;
            @(negedge clk);
            check_hex("wb_cyc", 32'(wb_cyc), 32'h0);
            check_hex("finish", 32'(finish), 32'(i == n - 1));
        end
        expect_idle(10); // Nothing issued after the last ack
    endtask

    initial begin
        logic [31:0] pick;
        lfsr   = 32'h3bdc_2fc4;
        rst    = 1'b1;
        start  = 1'b0;
        mode   = MODE_KEYGEN;
        wb_ack = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        expect_idle(2);
        check_hex("wb_stb", 32'(wb_stb), 32'h0);
        run_mode(MODE_KEYGEN);
        run_mode(MODE_ENC);
        run_mode(MODE_DEC);
        try_invalid_start();
        for (int k = 0; k < 9; k++) begin
            take_bits(2, pick);
            if (pick == 32'd3) begin
                try_invalid_start();
            end else begin
                run_mode(scheme_mode_t'(pick[1:0]));
            end
        end
        if (DUT.u_assert.fail_cnt == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            report_failure($sformatf("%0d bus assertion failures", DUT.u_assert.fail_cnt));
        end
    end

endmodule

// File: all.f
source/kyber_sched_pkg.sv
source/cmd_sequencer.sv
source/cmd_fifo.sv
source/ntt_issue.sv
source/kyber_sched_top.sv
verification/kyber_sched_assertions.sv
verification/kyber_sched_tb.sv

// File: Makefile
SIM       = verilator
TOP       = kyber_sched_tb
FILELIST  = all.f
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
RUNFLAGS  = +verilator+error+limit+100
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
